/* ac97_bus_read.sv */
// bus read multiplexer, acknowledge, record sample unpairing and status word
`default_nettype none

module ac97_bus_read import ac97_pkg::*; (
  input  wire              clk_adc_125mhz,                  // adc clock
  input  wire              adc_rstn_i,                      // sync reset, active low
  input  wire [31:0]       sys_addr_i,                      // bus address
  input  wire              sys_ren_i,                       // read strobe
  input  wire              sys_wen_i,                       // write strobe, ack only
  input  wire              rec_flush_i,                     // restart record pairing
  input  wire stereo_t     rec_data_i,                      // record fifo head
  input  wire              play_full_i,
  input  wire              play_half_full_i,
  input  wire              play_fault_i,                    // play underrun
  input  wire              rec_full_i,
  input  wire              rec_empty_i,
  input  wire              rec_fault_i,                     // record overrun
  input  wire              access_done_i,
  input  wire codec_word_t codec_rdata_i,
  output logic [31:0]      sys_rdata_o,                     // read data, valid with ack
  output logic             sys_ack_o,                       // one cycle after each strobe
  output logic             rec_pop_o                        // drop record head
);

  logic [19:0]         offset;
  logic                rec_is_right;                        // next record read gives right
  logic [SAMPLE_W-1:0] rec_sample;
  logic [31:0]         status_word;

  assign offset     = sys_addr_i[19:0];
  assign rec_sample = rec_is_right ? rec_data_i.right : rec_data_i.left;

  // ----------------------------------------------------------
  // status word
  always_comb begin
    status_word                    = '0;
    status_word[ST_PLAY_FULL]      = play_full_i;
    status_word[ST_PLAY_HALF_FULL] = play_half_full_i;
    status_word[ST_REC_FULL]       = rec_full_i;
    status_word[ST_REC_EMPTY]      = rec_empty_i;
    status_word[ST_ACCESS_DONE]    = access_done_i;
    status_word[ST_CODEC_READY]    = adc_rstn_i;            // codec ready whenever out of reset
    status_word[ST_PLAY_UNDERRUN]  = play_fault_i;
    status_word[ST_REC_OVERRUN]    = rec_fault_i;
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      sys_ack_o    <= 1'b0;
      rec_pop_o    <= 1'b0;
      rec_is_right <= 1'b0;
    end else begin
      sys_ack_o <= sys_ren_i || sys_wen_i;
      rec_pop_o <= sys_ren_i && (offset == REG_REC_FIFO) && rec_is_right;  // pop after right
      if (rec_flush_i) begin
        rec_is_right <= 1'b0;
      end else if (sys_ren_i && (offset == REG_REC_FIFO)) begin
        rec_is_right <= !rec_is_right;
      end
    end
  end

  // read data mux
  always_ff @(posedge clk_adc_125mhz) begin
    if (sys_ren_i) begin
      case (offset)
        REG_REC_FIFO:    sys_rdata_o <= 32'(rec_sample);
        REG_STATUS:      sys_rdata_o <= status_word;
        REG_CODEC_RDATA: sys_rdata_o <= 32'(codec_rdata_i);
        default:         sys_rdata_o <= '0;                 // unknown or write-only
      endcase
    end
  end

endmodule

`default_nettype wire

/* ac97_bus_write.sv */
// bus write decoder, pairs play samples, pulses fifo flushes and codec commands
`default_nettype none

module ac97_bus_write import ac97_pkg::*; (
  input  wire                     clk_adc_125mhz,           // adc clock
  input  wire                     adc_rstn_i,               // sync reset, active low
  input  wire  [31:0]             sys_addr_i,               // bus address
  input  wire  [31:0]             sys_wdata_i,              // bus write data
  input  wire                     sys_wen_i,                // write strobe
  output logic                    play_push_o,              // full pair ready
  output stereo_t                 play_data_o,              // assembled pair
  output logic                    play_flush_o,
  output logic                    rec_flush_o,
  output logic [CODEC_ADDR_W-1:0] codec_addr_o,             // held codec word address
  output codec_word_t             codec_wdata_o,            // held codec write data
  output logic                    codec_store_o,
  output logic                    codec_recall_o
);

  logic [19:0] offset;                                      // register offset
  logic        play_is_right;                               // next play write is the right one

  assign offset = sys_addr_i[19:0];

  // ----------------------------------------------------------
  // command pulses and pairing state
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      play_is_right  <= 1'b0;
      play_push_o    <= 1'b0;
      play_flush_o   <= 1'b0;
      rec_flush_o    <= 1'b0;
      codec_store_o  <= 1'b0;
      codec_recall_o <= 1'b0;
    end else begin
      play_push_o    <= 1'b0;                               // all pulses one cycle
      play_flush_o   <= 1'b0;
      rec_flush_o    <= 1'b0;
      codec_store_o  <= 1'b0;
      codec_recall_o <= 1'b0;
      if (sys_wen_i) begin
        case (offset)
          REG_PLAY_FIFO: begin
            play_is_right <= !play_is_right;
            play_push_o   <= play_is_right;                 // push after the right sample
          end
          REG_FIFO_RESET: begin
            play_flush_o <= sys_wdata_i[0];
            rec_flush_o  <= sys_wdata_i[1];
            if (sys_wdata_i[0]) begin
              play_is_right <= 1'b0;                        // pairing restarts at left
            end
          end
          REG_CODEC_ADDR: begin
            codec_store_o  <= !sys_wdata_i[7];              // bit 7 low stores
            codec_recall_o <= sys_wdata_i[7];               // bit 7 high recalls
          end
          default: ;
        endcase
      end
    end
  end

  // payload registers
  always_ff @(posedge clk_adc_125mhz) begin
    if (sys_wen_i) begin
      case (offset)
        REG_PLAY_FIFO: begin
          if (play_is_right) begin
            play_data_o.right <= sys_wdata_i[SAMPLE_W-1:0];
          end else begin
            play_data_o.left <= sys_wdata_i[SAMPLE_W-1:0];
          end
        end
        REG_CODEC_ADDR:  codec_addr_o  <= sys_wdata_i[CODEC_ADDR_W:1];  // byte to word address
        REG_CODEC_WDATA: codec_wdata_o <= sys_wdata_i[$bits(codec_word_t)-1:0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* ac97_codec_regs.sv */
// codec register file, 64 x 16, with store/recall sequencing and access-done flag
`default_nettype none

module ac97_codec_regs import ac97_pkg::*; (
  input  wire                    clk_adc_125mhz,            // adc clock
  input  wire                    adc_rstn_i,                // sync reset, active low
  input  wire [CODEC_ADDR_W-1:0] addr_i,                    // word address, held by the bus side
  input  wire codec_word_t       wdata_i,                   // word to store
  input  wire                    store_i,                   // write pulse
  input  wire                    recall_i,                  // read pulse
  output codec_word_t            rdata_o,                   // last recalled word
  output logic                   access_done_o              // command complete
);

  codec_word_t mem [2**CODEC_ADDR_W];                       // register image
  codec_word_t read_q;                                      // first read stage
  logic        store_q;                                     // store written last cycle
  logic        recall_q;                                    // read_q valid

  always_ff @(posedge clk_adc_125mhz) begin
    if (store_i) begin
      mem[addr_i] <= wdata_i;
    end
    if (recall_i) begin
      read_q <= mem[addr_i];                                // first stage reads the ram
    end
    if (recall_q) begin                                     // second stage adds the ready bits
      rdata_o <= read_q | ((addr_i == CODEC_STATUS_ADDR) ? CODEC_READY_MASK : '0);
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      store_q       <= 1'b0;
      recall_q      <= 1'b0;
      access_done_o <= 1'b0;
    end else begin
      store_q  <= store_i;
      recall_q <= recall_i;
      if (store_i || recall_i) begin
        access_done_o <= 1'b0;                              // new command pending
      end else if (store_q || recall_q) begin
        access_done_o <= 1'b1;                              // word settled
      end
    end
  end

endmodule

`default_nettype wire

/* ac97_ctrl_top.sv */
// ac97 controller top, rate strobes, play and record channels, codec registers, bus
`default_nettype none

module ac97_ctrl_top import ac97_pkg::*; #(
  parameter int PLAY_INTR_LEVEL = INTR_HALF_EMPTY,          // play irq level code
  parameter int REC_INTR_LEVEL  = INTR_HALF_FULL            // record irq level code
) (
  input  wire          clk_adc_125mhz,                      // adc clock
  input  wire          adc_rstn_i,                          // sync reset, active low
  input  wire stereo_t line_in_i,                           // record source
  input  wire [31:0]   sys_addr_i,
  input  wire [31:0]   sys_wdata_i,
  input  wire          sys_wen_i,
  input  wire          sys_ren_i,
  output wire [1:0]    ac97_clks_o,                         // {48k, 8k} strobes
  output wire stereo_t line_out_o,                          // play fifo head
  output wire          irq_play_o,
  output wire          irq_rec_o,
  output wire [31:0]   sys_rdata_o,
  output wire          sys_ack_o
);

  wire              tick_48k;
  wire              tick_8k;
  wire [NUM_CH-1:0] ch_push;
  wire [NUM_CH-1:0] ch_pop;
  wire [NUM_CH-1:0] ch_flush;
  wire [NUM_CH-1:0] ch_empty;
  wire [NUM_CH-1:0] ch_half_full;
  wire [NUM_CH-1:0] ch_full;
  wire [NUM_CH-1:0] ch_fault;
  wire [NUM_CH-1:0] ch_irq;
  wire stereo_t     ch_wdata [NUM_CH];
  wire stereo_t     ch_rdata [NUM_CH];
  wire [CODEC_ADDR_W-1:0] codec_addr;
  wire codec_word_t codec_wdata;
  wire codec_word_t codec_rdata;
  wire              codec_store;
  wire              codec_recall;
  wire              access_done;

  // ----------------------------------------------------------
  // sample strobes drive both fifo ends
  assign ch_pop[CH_PLAY]   = tick_48k;                      // drain play at 48 kHz
  assign ch_push[CH_REC]   = tick_48k;                      // capture line in
  assign ch_wdata[CH_REC]  = line_in_i;
  assign ac97_clks_o       = {tick_48k, tick_8k};
  assign line_out_o        = ch_rdata[CH_PLAY];
  assign irq_play_o        = ch_irq[CH_PLAY];
  assign irq_rec_o         = ch_irq[CH_REC];

  ac97_rate_gen i_rate_gen (
    .clk_adc_125mhz, .adc_rstn_i, .tick_48k_o(tick_48k), .tick_8k_o(tick_8k)
  );

  ac97_bus_write i_bus_write (
    .clk_adc_125mhz, .adc_rstn_i, .sys_addr_i, .sys_wdata_i, .sys_wen_i,
    .play_push_o(ch_push[CH_PLAY]), .play_data_o(ch_wdata[CH_PLAY]),
    .play_flush_o(ch_flush[CH_PLAY]), .rec_flush_o(ch_flush[CH_REC]),
    .codec_addr_o(codec_addr), .codec_wdata_o(codec_wdata),
    .codec_store_o(codec_store), .codec_recall_o(codec_recall)
  );

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    ac97_sample_channel #(
      .INTR_LEVEL((i == CH_PLAY) ? PLAY_INTR_LEVEL : REC_INTR_LEVEL)
    ) i_channel (
      .clk_adc_125mhz, .adc_rstn_i,
      .push_i(ch_push[i]), .pop_i(ch_pop[i]), .flush_i(ch_flush[i]),
      .wdata_i(ch_wdata[i]), .rdata_o(ch_rdata[i]),
      .empty_o(ch_empty[i]), .half_full_o(ch_half_full[i]), .full_o(ch_full[i]),
      .fault_o(ch_fault[i]), .irq_o(ch_irq[i])
    );
  end

  ac97_codec_regs i_codec_regs (
    .clk_adc_125mhz, .adc_rstn_i, .addr_i(codec_addr), .wdata_i(codec_wdata),
    .store_i(codec_store), .recall_i(codec_recall),
    .rdata_o(codec_rdata), .access_done_o(access_done)
  );

  ac97_bus_read i_bus_read (
    .clk_adc_125mhz, .adc_rstn_i, .sys_addr_i, .sys_ren_i, .sys_wen_i,
    .rec_flush_i(ch_flush[CH_REC]), .rec_data_i(ch_rdata[CH_REC]),
    .play_full_i(ch_full[CH_PLAY]), .play_half_full_i(ch_half_full[CH_PLAY]),
    .play_fault_i(ch_fault[CH_PLAY]), .rec_full_i(ch_full[CH_REC]),
    .rec_empty_i(ch_empty[CH_REC]), .rec_fault_i(ch_fault[CH_REC]),
    .access_done_i(access_done), .codec_rdata_i(codec_rdata),
    .sys_rdata_o, .sys_ack_o, .rec_pop_o(ch_pop[CH_REC])
  );

endmodule

`default_nettype wire

/* ac97_pkg.sv */
// ac97 controller shared widths, payload types, register map and status encodings
`default_nettype none

package ac97_pkg;

  // ----------------------------------------------------------
  // sample and fifo sizes
  localparam int SAMPLE_W   = 16;                           // one audio sample
  typedef struct packed {
    logic [SAMPLE_W-1:0] right;                             // high half
    logic [SAMPLE_W-1:0] left;                              // low half
  } stereo_t;
  localparam int FIFO_DEPTH = 16;
  typedef logic [$clog2(FIFO_DEPTH):0] fifo_count_t;        // one extra bit so full is visible
  localparam int NUM_CH     = 2;
  localparam int CH_PLAY    = 0;
  localparam int CH_REC     = 1;

  // codec register file
  localparam int CODEC_ADDR_W = 6;                          // word address
  typedef logic [15:0] codec_word_t;
  localparam logic [CODEC_ADDR_W-1:0] CODEC_STATUS_ADDR = 6'h13;  // byte 0x26
  localparam codec_word_t CODEC_READY_MASK = 16'h000F;      // forced ready bits

  // ----------------------------------------------------------
  // bus offsets, matched on addr[19:0]
  localparam logic [19:0] REG_PLAY_FIFO   = 20'h00000;
  localparam logic [19:0] REG_REC_FIFO    = 20'h00004;
  localparam logic [19:0] REG_STATUS      = 20'h00008;
  localparam logic [19:0] REG_FIFO_RESET  = 20'h0000C;
  localparam logic [19:0] REG_CODEC_ADDR  = 20'h00010;
  localparam logic [19:0] REG_CODEC_RDATA = 20'h00014;
  localparam logic [19:0] REG_CODEC_WDATA = 20'h00018;

  // status word bit positions
  localparam int ST_PLAY_FULL      = 0;
  localparam int ST_PLAY_HALF_FULL = 1;
  localparam int ST_REC_FULL       = 2;
  localparam int ST_REC_EMPTY      = 3;
  localparam int ST_ACCESS_DONE    = 4;
  localparam int ST_CODEC_READY    = 5;
  localparam int ST_PLAY_UNDERRUN  = 6;
  localparam int ST_REC_OVERRUN    = 7;

  // fifo interrupt level codes
  localparam int INTR_NONE       = 0;
  localparam int INTR_EMPTY      = 1;                       // count == 0
  localparam int INTR_HALF_EMPTY = 2;                       // count < 8
  localparam int INTR_HALF_FULL  = 3;                       // count >= 8
  localparam int INTR_FULL       = 4;                       // count == 16

  // 125 MHz / 48 kHz = 2604 + 1/6
  localparam int RATE_BASE_DIV   = 2604;
  localparam int RATE_FRAC_STEPS = 6;

endpackage

`default_nettype wire

/* ac97_rate_gen.sv */
// audio rate generator, fractional divider giving 48 kHz and 8 kHz one-cycle strobes
`default_nettype none

module ac97_rate_gen import ac97_pkg::*; (
  input  wire  clk_adc_125mhz,                              // adc clock
  input  wire  adc_rstn_i,                                  // sync reset, active low
  output logic tick_48k_o,                                  // 48 kHz strobe
  output logic tick_8k_o                                    // 8 kHz strobe
);

  localparam int CNT_W  = $clog2(RATE_BASE_DIV + 1);
  localparam int FRAC_W = $clog2(RATE_FRAC_STEPS);

  logic [CNT_W-1:0]  base_cnt;                              // cycles within one period
  logic [FRAC_W-1:0] frac_cnt;                              // period index 0..5
  logic              last_step;
  logic              period_end;

  assign last_step  = (frac_cnt == FRAC_W'(RATE_FRAC_STEPS - 1));
  // sixth period runs one cycle longer
  assign period_end = last_step ? (base_cnt == CNT_W'(RATE_BASE_DIV))
                                : (base_cnt == CNT_W'(RATE_BASE_DIV - 1));

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      base_cnt   <= '0;
      frac_cnt   <= '0;
      tick_48k_o <= 1'b0;
      tick_8k_o  <= 1'b0;
    end else begin
      tick_48k_o <= period_end;                             // one pulse per period
      tick_8k_o  <= period_end && last_step;                // every sixth 48k tick
      if (period_end) begin
        base_cnt <= '0;
        frac_cnt <= last_step ? '0 : frac_cnt + 1'b1;       // wrap after the long period
      end else begin
        base_cnt <= base_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* ac97_sample_channel.sv */
// stereo sample FIFO, 16 deep, with fill flags, level interrupt and run fault flag
`default_nettype none

module ac97_sample_channel import ac97_pkg::*; #(
  parameter int INTR_LEVEL = INTR_NONE                      // which fill level raises irq
) (
  input  wire          clk_adc_125mhz,                      // adc clock
  input  wire          adc_rstn_i,                          // sync reset, active low
  input  wire          push_i,                              // write one frame
  input  wire          pop_i,                               // drop head frame
  input  wire          flush_i,                             // empty fifo, clear irq and fault
  input  wire stereo_t wdata_i,                             // frame to push
  output stereo_t      rdata_o,                             // head frame
  output logic         empty_o,
  output logic         half_full_o,                         // count >= 8
  output logic         full_o,
  output logic         fault_o,                             // underrun or overrun seen
  output logic         irq_o                                // level interrupt, sticky
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  stereo_t          mem [FIFO_DEPTH];                       // frame storage
  logic [PTR_W-1:0] wr_ptr;                                 // tail
  logic [PTR_W-1:0] rd_ptr;                                 // head
  fifo_count_t      count;
  logic             do_push;
  logic             do_pop;
  logic             level_cond;                             // selected fill condition
  logic             level_cond_q;                           // last cycle's condition

  // ----------------------------------------------------------
  // flags straight from the count
  assign empty_o     = (count == '0);
  assign full_o      = (count == fifo_count_t'(FIFO_DEPTH));
  assign half_full_o = (count >= fifo_count_t'(FIFO_DEPTH / 2));
  assign do_push     = push_i && !full_o;                   // drop push when full
  assign do_pop      = pop_i && !empty_o;                   // drop pop when empty
  assign rdata_o     = mem[rd_ptr];

  always_ff @(posedge clk_adc_125mhz) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;                            // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                            // idle or push+pop
      endcase
    end
  end

  // ----------------------------------------------------------
  // level interrupt and fault
  always_comb begin
    case (INTR_LEVEL)
      INTR_EMPTY:      level_cond = empty_o;
      INTR_HALF_EMPTY: level_cond = !half_full_o;
      INTR_HALF_FULL:  level_cond = half_full_o;
      INTR_FULL:       level_cond = full_o;
      default:         level_cond = 1'b0;                   // irq disabled
    endcase
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      level_cond_q <= 1'b0;                                 // so a true level fires after reset
      irq_o        <= 1'b0;
      fault_o      <= 1'b0;
    end else begin
      level_cond_q <= level_cond;
      if (flush_i) begin
        irq_o   <= 1'b0;
        fault_o <= 1'b0;
      end else begin
        if (level_cond && !level_cond_q) begin
          irq_o <= 1'b1;                                    // rising edge of the level
        end
        if ((pop_i && empty_o) || (push_i && full_o)) begin
          fault_o <= 1'b1;                                  // underrun on play, overrun on rec
        end
      end
    end
  end

endmodule

`default_nettype wire

/* project.f */
ac97_pkg.sv
ac97_rate_gen.sv
ac97_sample_channel.sv
ac97_codec_regs.sv
ac97_bus_write.sv
ac97_bus_read.sv
ac97_ctrl_top.sv
tb_clk_gen.sv
tb_ac97_ctrl.sv

/* tb_ac97_ctrl.sv */
// testbench for the ac97 controller, bus, play, record and codec register checks
`default_nettype none

module tb_ac97_ctrl import ac97_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED         = 32'h83e5934b;
  localparam int          ACK_TIMEOUT  = 4;                 // cycles
  localparam int          TICK_TIMEOUT = 3000;              // one 48k period plus margin in cycles
  localparam int          POLL_LIMIT   = 8;                 // status polls
  localparam logic [5:0]  CODEC_ADDRS [5] = '{6'h00, 6'h07, 6'h13, 6'h2A, 6'h3F};

  logic        clk_adc_125mhz;
  logic        adc_rstn;
  stereo_t     line_in_i;
  logic [31:0] sys_addr_i;
  logic [31:0] sys_wdata_i;
  logic        sys_wen_i;
  logic        sys_ren_i;
  wire  [1:0]  ac97_clks_o;                                 // {48k, 8k}
  stereo_t     line_out_o;
  wire         irq_play_o;
  wire         irq_rec_o;
  wire  [31:0] sys_rdata_o;
  wire         sys_ack_o;

  stereo_t     play_q [$];                                  // fifo models
  stereo_t     rec_q  [$];
  logic        play_irq_exp;
  logic        rec_irq_exp;
  int          errors;
  int          checks;
  int          tests;
  int          err_at_start;
  int          tick48_cnt;                                  // 48 kHz strobes since reset

  tb_clk_gen i_clk_gen (.clk_o(clk_adc_125mhz), .rstn_o(adc_rstn));

  ac97_ctrl_top i_dut (
    .clk_adc_125mhz, .adc_rstn_i(adc_rstn), .line_in_i, .sys_addr_i, .sys_wdata_i,
    .sys_wen_i, .sys_ren_i, .ac97_clks_o, .line_out_o, .irq_play_o, .irq_rec_o,
    .sys_rdata_o, .sys_ack_o
  );

  always @(posedge clk_adc_125mhz) begin
    if (!adc_rstn) begin
      tick48_cnt <= 0;
    end else if (ac97_clks_o[1]) begin
      tick48_cnt <= tick48_cnt + 1;
    end
  end

  // ----------------------------------------------------------
  // protocol assertions
  ack_after_strobe: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o)
    else begin
      errors++;
      $display("FAIL %0t sys_ack_o got 0 exp 1", $time);
    end
  no_stray_ack: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn)
    !(sys_wen_i || sys_ren_i) |=> !sys_ack_o)
    else begin
      errors++;
      $display("FAIL %0t sys_ack_o got 1 exp 0", $time);
    end
  // 8 kHz strobe rides on every sixth 48 kHz strobe and nowhere else
  tick_8k_every_sixth: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn)
    ac97_clks_o[0] == (ac97_clks_o[1] && (tick48_cnt % 6 == 5)))
    else begin
      errors++;
      $display("FAIL %0t ac97_clks_o[0] got %b exp %b", $time,
               $sampled(ac97_clks_o[0]), !$sampled(ac97_clks_o[0]));
    end

  task automatic abort_run(input string why);
    $display("timeout at %0t ns: %s", $time, why);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("FAIL %0t %s got %h exp %h", $time, name, got, exp);
      end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %-8s %0d errors", tests, name, errors - err_at_start);
    err_at_start = errors;
  endtask

  function automatic stereo_t random_frame();
    random_frame = stereo_t'($urandom);
  endfunction

  // ----------------------------------------------------------
  // bus access driven on the falling edge
  task automatic wait_ack();
    int waited;
    waited = 0;
    while (!sys_ack_o) begin
      if (waited == ACK_TIMEOUT) abort_run("no bus acknowledge");
      @(negedge clk_adc_125mhz);
      waited++;
    end
  endtask

  task automatic bus_write(input logic [19:0] offs, input logic [31:0] data);
    @(negedge clk_adc_125mhz);
    sys_addr_i  = {12'h000, offs};
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    @(negedge clk_adc_125mhz);
    sys_wen_i   = 1'b0;                                     // one-cycle strobe
    wait_ack();
  endtask

  task automatic bus_read(input logic [19:0] offs, output logic [31:0] data);
    @(negedge clk_adc_125mhz);
    sys_addr_i = {12'h000, offs};
    sys_ren_i  = 1'b1;
    @(negedge clk_adc_125mhz);
    sys_ren_i  = 1'b0;
    wait_ack();
    data = sys_rdata_o;                                     // valid with ack
  endtask

  task automatic flush_fifos(input logic [1:0] which);
    bus_write(REG_FIFO_RESET, 32'(which));
    if (which[0]) begin
      play_q.delete();
      play_irq_exp = 1'b0;
    end
    if (which[1]) begin
      rec_q.delete();
      rec_irq_exp = 1'b0;
    end
  endtask

  task automatic wait_tick();
    int waited;
    waited = 0;
    do begin
      @(negedge clk_adc_125mhz);
      waited++;
      if (waited > TICK_TIMEOUT) abort_run("no 48 kHz strobe");
    end while (!ac97_clks_o[1]);
  endtask

  task automatic write_play_pair();
    stereo_t frame;
    frame = random_frame();
    bus_write(REG_PLAY_FIFO, 32'(frame.left));              // left first
    bus_write(REG_PLAY_FIFO, 32'(frame.right));
    play_q.push_back(frame);
  endtask

  // head is shown until the pop that follows the strobe
  task automatic play_tick_step();
    stereo_t head;
    wait_tick();
    if (play_q.size() > 0) begin
      head = play_q.pop_front();
      check_value("line_out_o", line_out_o, head);
    end
    repeat (2) @(negedge clk_adc_125mhz);                   // pop then irq update
    if (play_q.size() < FIFO_DEPTH / 2) play_irq_exp = 1'b1;
    check_value("irq_play_o", 32'(irq_play_o), 32'(play_irq_exp));
  endtask

  task automatic rec_tick_step();
    wait_tick();
    if (rec_q.size() < FIFO_DEPTH) rec_q.push_back(line_in_i);
    @(negedge clk_adc_125mhz);                              // push has taken line_in_i
    line_in_i = random_frame();
    @(negedge clk_adc_125mhz);
    if (rec_q.size() >= FIFO_DEPTH / 2) rec_irq_exp = 1'b1;
    check_value("irq_rec_o", 32'(irq_rec_o), 32'(rec_irq_exp));
  endtask

  task automatic wait_access_done();
    logic [31:0] st;
    int          polls;
    polls = 0;
    bus_read(REG_STATUS, st);
    while (!st[ST_ACCESS_DONE]) begin
      polls++;
      if (polls == POLL_LIMIT) abort_run("codec access never completed");
      bus_read(REG_STATUS, st);
    end
  endtask

  // ----------------------------------------------------------
  initial begin : stimulus
    logic [31:0] rd;
    logic [15:0] words [5];
    stereo_t     frame;
    int          waited;
    void'($urandom(SEED));
    line_in_i    = '0;
    sys_addr_i   = '0;
    sys_wdata_i  = '0;
    sys_wen_i    = 1'b0;
    sys_ren_i    = 1'b0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    err_at_start = 0;
    play_irq_exp = 1'b0;
    rec_irq_exp  = 1'b0;
    waited       = 0;
    while (adc_rstn !== 1'b1) begin
      if (waited == 10) abort_run("reset never released");
      @(negedge clk_adc_125mhz);
      waited++;
    end

    // test 1 covers acknowledge and reset state
    bus_read(REG_STATUS, rd);
    check_value("sys_rdata_o", rd, 32'((1 << ST_CODEC_READY) | (1 << ST_REC_EMPTY)));
    bus_read(20'h0001C, rd);                                // unknown offset
    check_value("sys_rdata_o", rd, 32'h0);
    bus_write(20'h00020, 32'hDEAD_BEEF);                    // unknown offset is still acked
    waited = 0;
    while (!irq_play_o) begin                               // play below half after reset
      if (waited == 8) abort_run("irq_play_o did not rise after reset");
      @(negedge clk_adc_125mhz);
      waited++;
    end
    end_test("ack");

    // test 2 covers playback and underrun
    wait_tick();
    flush_fifos(2'b01);
    repeat (8) write_play_pair();
    check_value("irq_play_o", 32'(irq_play_o), 32'(play_irq_exp));
    bus_read(REG_STATUS, rd);
    check_value("status play_half_full", 32'(rd[ST_PLAY_HALF_FULL]), 32'd1);
    check_value("status play_underrun", 32'(rd[ST_PLAY_UNDERRUN]), 32'd0);
    repeat (9) play_tick_step();                            // last one pops an empty fifo
    bus_read(REG_STATUS, rd);
    check_value("status play_underrun", 32'(rd[ST_PLAY_UNDERRUN]), 32'd1);
    flush_fifos(2'b01);
    bus_read(REG_STATUS, rd);
    check_value("status play_underrun", 32'(rd[ST_PLAY_UNDERRUN]), 32'd0);
    end_test("play");

    // test 3 covers the half-empty interrupt while draining
    wait_tick();
    flush_fifos(2'b01);
    repeat (10) write_play_pair();
    check_value("irq_play_o", 32'(irq_play_o), 32'd0);
    repeat (10) play_tick_step();
    end_test("play_irq");

    // test 4 covers record capture with unpairing, level irq and overrun
    wait_tick();
    flush_fifos(2'b10);
    line_in_i = random_frame();
    repeat (8) rec_tick_step();
    for (int i = 0; i < 8; i++) begin
      frame = rec_q.pop_front();
      bus_read(REG_REC_FIFO, rd);
      check_value("sys_rdata_o", rd, 32'(frame.left));
      bus_read(REG_REC_FIFO, rd);
      check_value("sys_rdata_o", rd, 32'(frame.right));
    end
    repeat (17) rec_tick_step();                            // one more than the depth
    bus_read(REG_STATUS, rd);
    check_value("status rec_full", 32'(rd[ST_REC_FULL]), 32'd1);
    check_value("status rec_overrun", 32'(rd[ST_REC_OVERRUN]), 32'd1);
    check_value("status rec_empty", 32'(rd[ST_REC_EMPTY]), 32'd0);
    frame = rec_q.pop_front();                              // oldest frame survives overrun
    bus_read(REG_REC_FIFO, rd);
    check_value("sys_rdata_o", rd, 32'(frame.left));
    bus_read(REG_REC_FIFO, rd);
    check_value("sys_rdata_o", rd, 32'(frame.right));
    end_test("record");

    // test 5 covers codec store then recall
    foreach (CODEC_ADDRS[i]) begin
      words[i] = 16'($urandom);
      bus_write(REG_CODEC_WDATA, 32'(words[i]));
      bus_write(REG_CODEC_ADDR, 32'({CODEC_ADDRS[i], 1'b0}));   // bit 7 low stores
      wait_access_done();
    end
    foreach (CODEC_ADDRS[i]) begin
      bus_write(REG_CODEC_ADDR, 32'h80 | 32'({CODEC_ADDRS[i], 1'b0}));
      wait_access_done();
      bus_read(REG_CODEC_RDATA, rd);
      check_value("sys_rdata_o", rd, 32'(words[i] |
                  ((CODEC_ADDRS[i] == 6'h13) ? 16'h000F : 16'h0000)));
    end
    end_test("codec");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// testbench clock and reset source, 8 ns clock with a reset held for 3 cycles
`default_nettype none

module tb_clk_gen #(
  parameter int RESET_CYCLES = 3                            // cycles of reset
) (
  output logic clk_o,                                       // 125 MHz adc clock
  output logic rstn_o                                       // sync reset, active low
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;                              // 8 ns period
  end

  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);                                       // release away from the sampling edge
    rstn_o = 1'b1;
  end

endmodule

`default_nettype wire
